/* src/gm_pkg.sv */
package gm_pkg;

	// ------------------------------------------------------------------
	// word and address geometry
	// ------------------------------------------------------------------
	localparam int DATA_WIDTH = 32;
	localparam int NUM_ENABLES = DATA_WIDTH / 8;
	localparam int ADDR_WIDTH = 32;

	// 8192 words of global memory
	localparam int MEM_ADDR_WIDTH = 13;
	localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

	// low address bits that pick a byte inside a word
	localparam int BYTE_OFFSET_WIDTH = 2;

	// highest byte address that maps onto the memory
	localparam int RANGE_HIGH = MEM_DEPTH * NUM_ENABLES - 1;

	// ------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------
	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [NUM_ENABLES-1:0] mask_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

	// sram controller states
	typedef enum logic [1:0]
	{
		idle,
		wait_write,
		read_mem,
		hold_read
	} ctrl_state_t;

endpackage

/* src/dtl_range_guard.sv */
module dtl_range_guard
	import gm_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// slave side, toward the port
	input  logic cmd_valid,
	input  logic cmd_read,
	input  addr_t cmd_addr,
	output logic cmd_accept,
	input  logic wr_valid,
	input  mask_t wr_mask,
	input  word_t wr_data,
	output logic wr_accept,
	output logic rd_valid,
	output word_t rd_data,
	input  logic rd_accept,

	// master side, toward the arbiter
	output logic out_cmd_valid,
	output logic out_cmd_read,
	output addr_t out_cmd_addr,
	input  logic out_cmd_accept,
	output logic out_wr_valid,
	output mask_t out_wr_mask,
	output word_t out_wr_data,
	input  logic out_wr_accept,
	input  logic out_rd_valid,
	input  word_t out_rd_data,
	output logic out_rd_accept
);

	logic out_of_range;
	logic err_accept;
	logic drop_wr;
	logic zero_rd;
	logic fwd_busy;
	logic local_busy;
	logic guard_free;

	assign out_of_range = cmd_addr > addr_t'(RANGE_HIGH);
	assign local_busy = drop_wr | zero_rd;
	assign guard_free = !local_busy && !fwd_busy;

	// in-range traffic passes straight through
	assign out_cmd_valid = cmd_valid && !out_of_range && guard_free;
	assign out_cmd_read = cmd_read;
	assign out_cmd_addr = cmd_addr;
	assign out_wr_valid = wr_valid && !drop_wr;
	assign out_wr_mask = wr_mask;
	assign out_wr_data = wr_data;
	assign out_rd_accept = rd_accept && !zero_rd;

	assign cmd_accept = (err_accept && cmd_valid) || (out_cmd_valid && out_cmd_accept);
	assign wr_accept = drop_wr ? wr_valid : out_wr_accept;
	assign rd_valid = zero_rd || out_rd_valid;
	assign rd_data = zero_rd ? '0 : out_rd_data;

	// out-of-range commands are answered here, one cycle late
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			err_accept <= 1'b0;
			drop_wr <= 1'b0;
			zero_rd <= 1'b0;
			fwd_busy <= 1'b0;
		end
		else
		begin
			err_accept <= cmd_valid && out_of_range && guard_free && !err_accept;
			if (err_accept && cmd_valid)
			begin
				drop_wr <= !cmd_read;
				zero_rd <= cmd_read;
			end
			else
			begin
				if (drop_wr && wr_valid)
					drop_wr <= 1'b0;
				if (zero_rd && rd_accept)
					zero_rd <= 1'b0;
			end
			if (out_cmd_valid && out_cmd_accept)
				fwd_busy <= 1'b1;
			else if ((out_wr_valid && out_wr_accept) || (out_rd_valid && out_rd_accept))
				fwd_busy <= 1'b0;
		end
	end

endmodule

/* src/dtl_arbiter.sv */
module dtl_arbiter
	import gm_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// slave 0
	input  logic s0_cmd_valid,
	input  logic s0_cmd_read,
	input  addr_t s0_cmd_addr,
	output logic s0_cmd_accept,
	input  logic s0_wr_valid,
	input  mask_t s0_wr_mask,
	input  word_t s0_wr_data,
	output logic s0_wr_accept,
	output logic s0_rd_valid,
	output word_t s0_rd_data,
	input  logic s0_rd_accept,

	// slave 1
	input  logic s1_cmd_valid,
	input  logic s1_cmd_read,
	input  addr_t s1_cmd_addr,
	output logic s1_cmd_accept,
	input  logic s1_wr_valid,
	input  mask_t s1_wr_mask,
	input  word_t s1_wr_data,
	output logic s1_wr_accept,
	output logic s1_rd_valid,
	output word_t s1_rd_data,
	input  logic s1_rd_accept,

	// merged master
	output logic m_cmd_valid,
	output logic m_cmd_read,
	output addr_t m_cmd_addr,
	input  logic m_cmd_accept,
	output logic m_wr_valid,
	output mask_t m_wr_mask,
	output word_t m_wr_data,
	input  logic m_wr_accept,
	input  logic m_rd_valid,
	input  word_t m_rd_data,
	output logic m_rd_accept
);

	logic busy;
	logic grant;
	logic rr_ptr;
	logic sel;
	logic cur;
	logic done;

	// round robin pick, only looked at while the bus is free
	assign sel = (s0_cmd_valid && s1_cmd_valid) ? rr_ptr : s1_cmd_valid;
	assign cur = busy ? grant : sel;

	assign m_cmd_valid = !busy && (s0_cmd_valid || s1_cmd_valid);
	assign m_cmd_read = cur ? s1_cmd_read : s0_cmd_read;
	assign m_cmd_addr = cur ? s1_cmd_addr : s0_cmd_addr;
	assign m_wr_valid = busy && (cur ? s1_wr_valid : s0_wr_valid);
	assign m_wr_mask = cur ? s1_wr_mask : s0_wr_mask;
	assign m_wr_data = cur ? s1_wr_data : s0_wr_data;
	assign m_rd_accept = busy && (cur ? s1_rd_accept : s0_rd_accept);

	// answers go back to the granted side only
	assign s0_cmd_accept = m_cmd_valid && m_cmd_accept && !cur;
	assign s1_cmd_accept = m_cmd_valid && m_cmd_accept && cur;
	assign s0_wr_accept = m_wr_valid && m_wr_accept && !cur;
	assign s1_wr_accept = m_wr_valid && m_wr_accept && cur;
	assign s0_rd_valid = busy && m_rd_valid && !cur;
	assign s1_rd_valid = busy && m_rd_valid && cur;
	assign s0_rd_data = m_rd_data;
	assign s1_rd_data = m_rd_data;

	assign done = (m_wr_valid && m_wr_accept) || (m_rd_valid && m_rd_accept);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			grant <= 1'b0;
			rr_ptr <= 1'b0;
		end
		else if (m_cmd_valid && m_cmd_accept)
		begin
			busy <= 1'b1;
			grant <= sel;
			rr_ptr <= !sel;
		end
		else if (done)
			busy <= 1'b0;
	end

endmodule

/* src/dtl_sram_ctrl.sv */
module dtl_sram_ctrl
	import gm_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// merged slave port
	input  logic cmd_valid,
	input  logic cmd_read,
	input  addr_t cmd_addr,
	output logic cmd_accept,
	input  logic wr_valid,
	input  mask_t wr_mask,
	input  word_t wr_data,
	output logic wr_accept,
	output logic rd_valid,
	output word_t rd_data,
	input  logic rd_accept,

	// ram side
	output mem_addr_t ram_addr,
	output mask_t ram_wbe,
	output word_t ram_wr_data,
	input  word_t ram_rd_data
);

	ctrl_state_t state;
	mem_addr_t addr_q;
	mem_addr_t cmd_index;
	word_t rd_hold;

	// word index, byte offset dropped
	assign cmd_index = cmd_addr[BYTE_OFFSET_WIDTH +: MEM_ADDR_WIDTH];

	// ------------------------------------------------------------------
	// handshake outputs
	// ------------------------------------------------------------------
	assign cmd_accept = (state == idle) && cmd_valid;
	assign wr_accept = (state == wait_write) && wr_valid;
	assign rd_valid = (state == hold_read);
	assign rd_data = rd_hold;

	// ------------------------------------------------------------------
	// ram drive
	// ------------------------------------------------------------------
	// the read address is presented while the command is accepted
	assign ram_addr = (state == idle) ? cmd_index : addr_q;
	assign ram_wbe = wr_accept ? wr_mask : '0;
	assign ram_wr_data = wr_data;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= idle;
		else
		begin
			case (state)
				idle:
				begin
					if (cmd_valid)
						state <= cmd_read ? read_mem : wait_write;
				end
				wait_write:
				begin
					if (wr_valid)
						state <= idle;
				end
				read_mem:
					state <= hold_read;
				hold_read:
				begin
					if (rd_accept)
						state <= idle;
				end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_accept)
			addr_q <= cmd_index;
		// ram output is ready one cycle after the address
		if (state == read_mem)
			rd_hold <= ram_rd_data;
	end

endmodule

/* src/gm_ram.sv */
module gm_ram
	import gm_pkg::*;
(
	input  logic clk,
	input  mem_addr_t addr,
	input  mask_t wbe,
	input  word_t wr_data,
	output word_t rd_data
);

	word_t mem [0:MEM_DEPTH-1];

	// byte lane writes
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_ENABLES; i++)
		begin
			if (wbe[i])
				mem[addr][8*i +: 8] <= wr_data[8*i +: 8];
		end
	end

	// registered read, returns the old word on a same-cycle write
	always_ff @(posedge clk)
	begin
		rd_data <= mem[addr];
	end

endmodule

/* src/gm_subsystem_top.sv */
module gm_subsystem_top
	import gm_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// host port
	input  logic host_cmd_valid,
	input  logic host_cmd_read,
	input  addr_t host_cmd_addr,
	output logic host_cmd_accept,
	input  logic host_wr_valid,
	input  mask_t host_wr_mask,
	input  word_t host_wr_data,
	output logic host_wr_accept,
	output logic host_rd_valid,
	output word_t host_rd_data,
	input  logic host_rd_accept,

	// core port
	input  logic core_cmd_valid,
	input  logic core_cmd_read,
	input  addr_t core_cmd_addr,
	output logic core_cmd_accept,
	input  logic core_wr_valid,
	input  mask_t core_wr_mask,
	input  word_t core_wr_data,
	output logic core_wr_accept,
	output logic core_rd_valid,
	output word_t core_rd_data,
	input  logic core_rd_accept
);

	logic g0_cmd_valid, g0_cmd_read, g0_cmd_accept;
	logic g0_wr_valid, g0_wr_accept, g0_rd_valid, g0_rd_accept;
	addr_t g0_cmd_addr;
	mask_t g0_wr_mask;
	word_t g0_wr_data, g0_rd_data;

	logic g1_cmd_valid, g1_cmd_read, g1_cmd_accept;
	logic g1_wr_valid, g1_wr_accept, g1_rd_valid, g1_rd_accept;
	addr_t g1_cmd_addr;
	mask_t g1_wr_mask;
	word_t g1_wr_data, g1_rd_data;

	logic m_cmd_valid, m_cmd_read, m_cmd_accept;
	logic m_wr_valid, m_wr_accept, m_rd_valid, m_rd_accept;
	addr_t m_cmd_addr;
	mask_t m_wr_mask;
	word_t m_wr_data, m_rd_data;

	mem_addr_t ram_addr;
	mask_t ram_wbe;
	word_t ram_wr_data, ram_rd_data;

	// ------------------------------------------------------------------
	// address guards, one per port
	// ------------------------------------------------------------------
	dtl_range_guard guard_host
	(
		.clk(clk), .reset(reset),
		.cmd_valid(host_cmd_valid), .cmd_read(host_cmd_read), .cmd_addr(host_cmd_addr),
		.cmd_accept(host_cmd_accept),
		.wr_valid(host_wr_valid), .wr_mask(host_wr_mask), .wr_data(host_wr_data),
		.wr_accept(host_wr_accept),
		.rd_valid(host_rd_valid), .rd_data(host_rd_data), .rd_accept(host_rd_accept),
		.out_cmd_valid(g0_cmd_valid), .out_cmd_read(g0_cmd_read), .out_cmd_addr(g0_cmd_addr),
		.out_cmd_accept(g0_cmd_accept),
		.out_wr_valid(g0_wr_valid), .out_wr_mask(g0_wr_mask), .out_wr_data(g0_wr_data),
		.out_wr_accept(g0_wr_accept),
		.out_rd_valid(g0_rd_valid), .out_rd_data(g0_rd_data), .out_rd_accept(g0_rd_accept)
	);

	dtl_range_guard guard_core
	(
		.clk(clk), .reset(reset),
		.cmd_valid(core_cmd_valid), .cmd_read(core_cmd_read), .cmd_addr(core_cmd_addr),
		.cmd_accept(core_cmd_accept),
		.wr_valid(core_wr_valid), .wr_mask(core_wr_mask), .wr_data(core_wr_data),
		.wr_accept(core_wr_accept),
		.rd_valid(core_rd_valid), .rd_data(core_rd_data), .rd_accept(core_rd_accept),
		.out_cmd_valid(g1_cmd_valid), .out_cmd_read(g1_cmd_read), .out_cmd_addr(g1_cmd_addr),
		.out_cmd_accept(g1_cmd_accept),
		.out_wr_valid(g1_wr_valid), .out_wr_mask(g1_wr_mask), .out_wr_data(g1_wr_data),
		.out_wr_accept(g1_wr_accept),
		.out_rd_valid(g1_rd_valid), .out_rd_data(g1_rd_data), .out_rd_accept(g1_rd_accept)
	);

	// ------------------------------------------------------------------
	// arbiter, controller and memory
	// ------------------------------------------------------------------
	dtl_arbiter i_dtl_arbiter
	(
		.clk(clk), .reset(reset),
		.s0_cmd_valid(g0_cmd_valid), .s0_cmd_read(g0_cmd_read), .s0_cmd_addr(g0_cmd_addr),
		.s0_cmd_accept(g0_cmd_accept),
		.s0_wr_valid(g0_wr_valid), .s0_wr_mask(g0_wr_mask), .s0_wr_data(g0_wr_data),
		.s0_wr_accept(g0_wr_accept),
		.s0_rd_valid(g0_rd_valid), .s0_rd_data(g0_rd_data), .s0_rd_accept(g0_rd_accept),
		.s1_cmd_valid(g1_cmd_valid), .s1_cmd_read(g1_cmd_read), .s1_cmd_addr(g1_cmd_addr),
		.s1_cmd_accept(g1_cmd_accept),
		.s1_wr_valid(g1_wr_valid), .s1_wr_mask(g1_wr_mask), .s1_wr_data(g1_wr_data),
		.s1_wr_accept(g1_wr_accept),
		.s1_rd_valid(g1_rd_valid), .s1_rd_data(g1_rd_data), .s1_rd_accept(g1_rd_accept),
		.m_cmd_valid(m_cmd_valid), .m_cmd_read(m_cmd_read), .m_cmd_addr(m_cmd_addr),
		.m_cmd_accept(m_cmd_accept),
		.m_wr_valid(m_wr_valid), .m_wr_mask(m_wr_mask), .m_wr_data(m_wr_data),
		.m_wr_accept(m_wr_accept),
		.m_rd_valid(m_rd_valid), .m_rd_data(m_rd_data), .m_rd_accept(m_rd_accept)
	);

	dtl_sram_ctrl i_dtl_sram_ctrl
	(
		.clk(clk), .reset(reset),
		.cmd_valid(m_cmd_valid), .cmd_read(m_cmd_read), .cmd_addr(m_cmd_addr),
		.cmd_accept(m_cmd_accept),
		.wr_valid(m_wr_valid), .wr_mask(m_wr_mask), .wr_data(m_wr_data),
		.wr_accept(m_wr_accept),
		.rd_valid(m_rd_valid), .rd_data(m_rd_data), .rd_accept(m_rd_accept),
		.ram_addr(ram_addr), .ram_wbe(ram_wbe),
		.ram_wr_data(ram_wr_data), .ram_rd_data(ram_rd_data)
	);

	gm_ram i_gm_ram
	(
		.clk(clk),
		.addr(ram_addr),
		.wbe(ram_wbe),
		.wr_data(ram_wr_data),
		.rd_data(ram_rd_data)
	);

endmodule

/* verif/tb_clock.sv */
module tb_clock
(
	output logic clk
);

	localparam int HALF_PERIOD = 10;

	// free running clock, period 20
	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

endmodule

/* verif/gm_sva.sv */
module gm_sva
	import gm_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic host_wr_accept,
	input logic host_rd_valid,
	input word_t host_rd_data,
	input logic host_rd_accept,
	input logic core_wr_accept,
	input logic core_rd_valid,
	input word_t core_rd_data,
	input logic core_rd_accept,
	input logic g0_cmd_valid,
	input logic g0_cmd_accept,
	input logic g1_cmd_valid,
	input logic g1_cmd_accept
);

	// a read result holds until the port takes it
	assert property (@(posedge clk) disable iff (reset)
		host_rd_valid && !host_rd_accept |=> host_rd_valid && $stable(host_rd_data))
		else $error("host read result dropped or changed before it was accepted");
	assert property (@(posedge clk) disable iff (reset)
		core_rd_valid && !core_rd_accept |=> core_rd_valid && $stable(core_rd_data))
		else $error("core read result dropped or changed before it was accepted");

	// the arbiter answers only a side that presents a command
	assert property (@(posedge clk) disable iff (reset) g0_cmd_accept |-> g0_cmd_valid)
		else $error("host side command accepted by the arbiter with no command pending");
	assert property (@(posedge clk) disable iff (reset) g1_cmd_accept |-> g1_cmd_valid)
		else $error("core side command accepted by the arbiter with no command pending");

	// nothing completes while reset is held
	assert property (@(posedge clk) reset && $past(reset) |->
		!host_rd_valid && !host_wr_accept && !core_rd_valid && !core_wr_accept)
		else $error("read valid or write accept seen during reset");

endmodule

bind gm_subsystem_top gm_sva i_gm_sva (.*);

/* verif/gm_tb.sv */
module gm_tb
	import gm_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int SEED = 34612;
	localparam int N_FULL = 16;
	localparam int N_PARTIAL = 8;
	localparam int N_SHARED = 8;
	localparam int N_OOB = 4;
	localparam int N_STREAM = 12;
	localparam int NUM_TXN = 2*N_FULL + 3*N_PARTIAL + 4*N_SHARED + 4*N_OOB + 4*N_STREAM + 8;
	localparam int TXN_CYCLES = 40;
	localparam int WATCHDOG_TIME = (RESET_CYCLES + NUM_TXN * TXN_CYCLES) * CLK_PERIOD;

	logic clk;
	logic reset;

	// index 0 is the host port, index 1 the core port
	logic [1:0] cmd_valid;
	logic [1:0] cmd_read;
	addr_t [1:0] cmd_addr;
	logic [1:0] wr_valid;
	mask_t [1:0] wr_mask;
	word_t [1:0] wr_data;
	logic [1:0] rd_accept;
	wire [1:0] cmd_accept;
	wire [1:0] wr_accept;
	wire [1:0] rd_valid;
	wire [1:0][DATA_WIDTH-1:0] rd_data;

	word_t ref_mem [0:MEM_DEPTH-1];
	time wr_done [0:1];
	time rd_done [0:1];
	int errors;
	int checks;
	int tests_run;
	int unsigned seed_value;

	tb_clock i_tb_clock
	(
		.clk(clk)
	);

	gm_subsystem_top i_gm_subsystem_top
	(
		.clk(clk), .reset(reset),
		.host_cmd_valid(cmd_valid[0]), .host_cmd_read(cmd_read[0]),
		.host_cmd_addr(cmd_addr[0]), .host_cmd_accept(cmd_accept[0]),
		.host_wr_valid(wr_valid[0]), .host_wr_mask(wr_mask[0]),
		.host_wr_data(wr_data[0]), .host_wr_accept(wr_accept[0]),
		.host_rd_valid(rd_valid[0]), .host_rd_data(rd_data[0]),
		.host_rd_accept(rd_accept[0]),
		.core_cmd_valid(cmd_valid[1]), .core_cmd_read(cmd_read[1]),
		.core_cmd_addr(cmd_addr[1]), .core_cmd_accept(cmd_accept[1]),
		.core_wr_valid(wr_valid[1]), .core_wr_mask(wr_mask[1]),
		.core_wr_data(wr_data[1]), .core_wr_accept(wr_accept[1]),
		.core_rd_valid(rd_valid[1]), .core_rd_data(rd_data[1]),
		.core_rd_accept(rd_accept[1])
	);

	// ------------------------------------------------------------------
	// reference model and port helpers
	// ------------------------------------------------------------------
	function automatic mem_addr_t word_index(input addr_t a);
		return mem_addr_t'(a >> BYTE_OFFSET_WIDTH);
	endfunction

	function automatic addr_t random_addr(input int base, input int span);
		addr_t a;
		a = addr_t'(base) + addr_t'($urandom % span);
		return (a << BYTE_OFFSET_WIDTH) | addr_t'($urandom % NUM_ENABLES);
	endfunction

	task automatic write_word(input int p, input addr_t a, input mask_t m, input word_t d);
		@(negedge clk);
		cmd_valid[p] = 1'b1;
		cmd_read[p] = 1'b0;
		cmd_addr[p] = a;
		do
			@(posedge clk);
		while (!cmd_accept[p]);
		@(negedge clk);
		cmd_valid[p] = 1'b0;
		wr_valid[p] = 1'b1;
		wr_mask[p] = m;
		wr_data[p] = d;
		do
			@(posedge clk);
		while (!wr_accept[p]);
		wr_done[p] = $time;
		@(negedge clk);
		wr_valid[p] = 1'b0;
		// out of range writes are dropped, so memory keeps its old bytes
		if (a <= addr_t'(RANGE_HIGH))
		begin
			for (int i = 0; i < NUM_ENABLES; i++)
			begin
				if (m[i])
					ref_mem[word_index(a)][8*i +: 8] = d[8*i +: 8];
			end
		end
	endtask

	task automatic read_word(input int p, input addr_t a, input int stall);
		word_t first;
		word_t got;
		word_t exp;
		@(negedge clk);
		cmd_valid[p] = 1'b1;
		cmd_read[p] = 1'b1;
		cmd_addr[p] = a;
		do
			@(posedge clk);
		while (!cmd_accept[p]);
		@(negedge clk);
		cmd_valid[p] = 1'b0;
		rd_accept[p] = (stall == 0);
		do
			@(posedge clk);
		while (!rd_valid[p]);
		first = rd_data[p];
		for (int i = 0; i < stall; i++)
		begin
			@(posedge clk);
			checks++;
			if (!rd_valid[p] || rd_data[p] !== first)
			begin
				errors++;
				$display("MISMATCH at %0t: port %0d read result not held while stalled",
					$time, p);
			end
		end
		if (stall > 0)
		begin
			@(negedge clk);
			rd_accept[p] = 1'b1;
			@(posedge clk);
		end
		got = rd_data[p];
		rd_done[p] = $time;
		@(negedge clk);
		rd_accept[p] = 1'b0;
		exp = (a > addr_t'(RANGE_HIGH)) ? '0 : ref_mem[word_index(a)];
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0t: port %0d read of %h returned %h, expected %h",
				$time, p, a, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
			$display("%s: passed", name);
		else
			$display("%s: failed with %0d errors", name, errors - err_start);
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic test_full_words();
		addr_t addrs [N_FULL];
		int err_start;
		err_start = errors;
		for (int i = 0; i < N_FULL; i++)
		begin
			addrs[i] = random_addr(0, MEM_DEPTH);
			write_word(0, addrs[i], '1, word_t'($urandom));
		end
		for (int i = 0; i < N_FULL; i++)
			read_word(0, addrs[i], 0);
		report_test("full word write and read back", err_start);
	endtask

	task automatic test_partial_masks();
		addr_t a;
		int err_start;
		err_start = errors;
		for (int i = 0; i < N_PARTIAL; i++)
		begin
			a = random_addr(0, MEM_DEPTH);
			write_word(0, a, '1, word_t'($urandom));
			write_word(0, a, mask_t'($urandom), word_t'($urandom));
			read_word(0, a, 0);
		end
		report_test("byte masked writes", err_start);
	endtask

	task automatic test_shared_memory();
		addr_t a;
		int err_start;
		err_start = errors;
		for (int i = 0; i < N_SHARED; i++)
		begin
			a = random_addr(0, MEM_DEPTH);
			write_word(1, a, '1, word_t'($urandom));
			read_word(0, a, 0);
			a = random_addr(0, MEM_DEPTH);
			write_word(0, a, '1, word_t'($urandom));
			read_word(1, a, 0);
		end
		report_test("shared memory across ports", err_start);
	endtask

	task automatic test_out_of_range();
		addr_t a;
		addr_t bad;
		int p;
		int err_start;
		err_start = errors;
		for (int i = 0; i < N_OOB; i++)
		begin
			p = i % 2;
			a = random_addr(0, MEM_DEPTH);
			// both forms keep the low bits of the in-range word
			bad = (i < 2) ? a + addr_t'(RANGE_HIGH) + 1 : a | 32'h8000_0000;
			write_word(p, a, '1, word_t'($urandom));
			write_word(p, bad, '1, word_t'($urandom));
			read_word(p, bad, 0);
			read_word(1 - p, a, 0);
		end
		report_test("out of range commands", err_start);
	endtask

	task automatic run_stream(input int p);
		addr_t addrs [N_STREAM];
		for (int i = 0; i < N_STREAM; i++)
		begin
			// host keeps to the lower half, core to the upper half
			addrs[i] = random_addr(p * MEM_DEPTH / 2, MEM_DEPTH / 2);
			write_word(p, addrs[i], '1, word_t'($urandom));
		end
		for (int i = 0; i < N_STREAM; i++)
			read_word(p, addrs[i], 0);
	endtask

	task automatic test_concurrent();
		int err_start;
		err_start = errors;
		fork
			run_stream(0);
			run_stream(1);
		join
		report_test("concurrent streams on both ports", err_start);
	endtask

	task automatic test_read_stall();
		addr_t a;
		addr_t b;
		int stall;
		int err_start;
		err_start = errors;
		a = random_addr(0, MEM_DEPTH / 2);
		b = random_addr(MEM_DEPTH / 2, MEM_DEPTH / 2);
		stall = 4 + int'($urandom % 12);
		write_word(0, a, '1, word_t'($urandom));
		write_word(1, b, '1, word_t'($urandom));
		fork
			read_word(0, a, stall);
			begin
				repeat (3) @(negedge clk);
				write_word(1, b, '1, word_t'($urandom));
			end
		join
		checks++;
		if (wr_done[1] <= rd_done[0])
		begin
			errors++;
			$display("core write finished at %0t, before the stalled host read at %0t",
				wr_done[1], rd_done[0]);
		end
		read_word(0, b, 0);
		report_test("read back-pressure", err_start);
	endtask

	// ------------------------------------------------------------------
	// run control
	// ------------------------------------------------------------------
	initial
	begin
		#(WATCHDOG_TIME);
		$display("timeout: tests did not finish within %0d time units", WATCHDOG_TIME);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		seed_value = $urandom(SEED);
		errors = 0;
		checks = 0;
		tests_run = 0;
		wr_done = '{0, 0};
		rd_done = '{0, 0};
		reset = 1'b1;
		cmd_valid = '0;
		cmd_read = '0;
		cmd_addr = '0;
		wr_valid = '0;
		wr_mask = '0;
		wr_data = '0;
		rd_accept = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		test_full_words();
		test_partial_masks();
		test_shared_memory();
		test_out_of_range();
		test_concurrent();
		test_read_stall();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* files.f */
src/gm_pkg.sv
src/dtl_range_guard.sv
src/dtl_arbiter.sv
src/dtl_sram_ctrl.sv
src/gm_ram.sv
src/gm_subsystem_top.sv
verif/tb_clock.sv
verif/gm_sva.sv
verif/gm_tb.sv

/* Makefile */
TOP = gm_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -o V$(TOP)

# the run passes only if the pass line shows up in the log
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log
